//--- hw/timer_pkg.sv
package timer_pkg;

    // Datapath and bus widths
    localparam int COUNT_W = 32;
    localparam int ADDR_W  = 3;
    localparam int EVENT_W = 8;

    // Word addresses on the Wishbone port
    localparam logic [ADDR_W-1:0] REG_CTRL   = 3'd0;
    localparam logic [ADDR_W-1:0] REG_LOAD   = 3'd1;
    localparam logic [ADDR_W-1:0] REG_DUTY   = 3'd2;
    localparam logic [ADDR_W-1:0] REG_STATUS = 3'd3;
    localparam logic [ADDR_W-1:0] REG_COUNT  = 3'd4;

    // Control word bit positions
    localparam int CTRL_START    = 0;  // Self-clearing, reads as zero
    localparam int CTRL_ONE_SHOT = 1;
    localparam int CTRL_PERIODIC = 2;
    localparam int CTRL_PWM      = 3;
    localparam int CTRL_OFF      = 4;
    localparam int CTRL_IRQ_EN   = 5;

    // Status word layout
    localparam int STAT_TIMEOUT    = 0;  // Sticky, write one to clear
    localparam int STAT_EVENTS_LSB = 8;  // Event count field start

    // Mode machine states
    typedef enum logic [2:0] {
        IDLE     = 3'b000,
        RUNNING  = 3'b001,
        ONE_SHOT = 3'b010,
        PERIODIC = 3'b011,
        PWM      = 3'b100,
        PWM_RUN  = 3'b101,
        OFF      = 3'b110
    } state_t;

endpackage

//--- hw/timer_regs.sv
`timescale 1ns/1ps

module timer_regs (
    input  logic                                prescaled_clk,
    input  logic                                reset_n,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [timer_pkg::ADDR_W-1:0]        wb_adr,
    input  logic [timer_pkg::COUNT_W-1:0]       wb_dat_w,
    input  logic [timer_pkg::COUNT_W-1:0]       current_count,
    input  logic                                status_flag,
    input  logic [timer_pkg::EVENT_W-1:0]       event_count,
    output logic [timer_pkg::COUNT_W-1:0]       wb_dat_r,
    output logic                                wb_ack,
    output logic                                start,
    output logic                                one_shot,
    output logic                                periodic,
    output logic                                pwm_mode,
    output logic                                off_signal,
    output logic                                irq_en,
    output logic [timer_pkg::COUNT_W-1:0]       load_value,
    output logic [timer_pkg::COUNT_W-1:0]       duty_value,
    output logic                                status_clear
);

    logic                          access;
    logic                          wr_en;
    logic [timer_pkg::COUNT_W-1:0] ctrl_word;
    logic [timer_pkg::COUNT_W-1:0] status_word;

    assign access = wb_cyc && wb_stb && !wb_ack;  // First cycle of a bus cycle
    assign wr_en  = access && wb_we;

    // Read-back views of the control and status registers
    always_comb begin
        ctrl_word = '0;
        ctrl_word[timer_pkg::CTRL_ONE_SHOT] = one_shot;
        ctrl_word[timer_pkg::CTRL_PERIODIC] = periodic;
        ctrl_word[timer_pkg::CTRL_PWM]      = pwm_mode;
        ctrl_word[timer_pkg::CTRL_OFF]      = off_signal;
        ctrl_word[timer_pkg::CTRL_IRQ_EN]   = irq_en;
    end

    always_comb begin
        status_word = '0;
        status_word[timer_pkg::STAT_TIMEOUT] = status_flag;
        status_word[timer_pkg::STAT_EVENTS_LSB +: timer_pkg::EVENT_W] = event_count;
    end

    always_ff @(posedge prescaled_clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_ack       <= 1'b0;
            start        <= 1'b0;
            status_clear <= 1'b0;
            one_shot     <= 1'b0;
            periodic     <= 1'b0;
            pwm_mode     <= 1'b0;
            off_signal   <= 1'b0;
            irq_en       <= 1'b0;
            load_value   <= '0;
            duty_value   <= '0;
        end else begin
            wb_ack       <= access;  // One cycle per access
            start        <= 1'b0;
            status_clear <= 1'b0;
            if (wr_en) begin
                case (wb_adr)
                    timer_pkg::REG_CTRL: begin
                        start      <= wb_dat_w[timer_pkg::CTRL_START];
                        one_shot   <= wb_dat_w[timer_pkg::CTRL_ONE_SHOT];
                        periodic   <= wb_dat_w[timer_pkg::CTRL_PERIODIC];
                        pwm_mode   <= wb_dat_w[timer_pkg::CTRL_PWM];
                        off_signal <= wb_dat_w[timer_pkg::CTRL_OFF];
                        irq_en     <= wb_dat_w[timer_pkg::CTRL_IRQ_EN];
                    end
                    timer_pkg::REG_LOAD:   load_value   <= wb_dat_w;
                    timer_pkg::REG_DUTY:   duty_value   <= wb_dat_w;
                    timer_pkg::REG_STATUS: status_clear <= wb_dat_w[timer_pkg::STAT_TIMEOUT];
                    default: ;  // Unmapped address drops the write
                endcase
            end
        end
    end

    // Registered read mux
    always_ff @(posedge prescaled_clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_dat_r <= '0;
        end else if (access) begin
            case (wb_adr)
                timer_pkg::REG_CTRL:   wb_dat_r <= ctrl_word;
                timer_pkg::REG_LOAD:   wb_dat_r <= load_value;
                timer_pkg::REG_DUTY:   wb_dat_r <= duty_value;
                timer_pkg::REG_STATUS: wb_dat_r <= status_word;
                timer_pkg::REG_COUNT:  wb_dat_r <= current_count;
                default:               wb_dat_r <= '0;
            endcase
        end
    end

endmodule

//--- hw/count_fsm.sv
`timescale 1ns/1ps

module count_fsm (
    input  logic                          prescaled_clk,
    input  logic                          reset_n,
    input  logic                          start,
    input  logic                          one_shot,
    input  logic                          periodic,
    input  logic                          pwm_mode,
    input  logic                          off_signal,
    input  logic [timer_pkg::COUNT_W-1:0] current_count,
    output logic                          enable,
    output logic                          reload_signal,
    output logic                          pwm_signal,
    output logic                          timeout
);

    timer_pkg::state_t c_state;
    timer_pkg::state_t n_state;
    logic              at_zero;

    assign at_zero = (current_count == '0);

    always_ff @(posedge prescaled_clk or negedge reset_n) begin
        if (!reset_n) begin
            c_state <= timer_pkg::IDLE;
        end else begin
            c_state <= n_state;
        end
    end

    always_comb begin
        n_state = c_state;
        case (c_state)
            timer_pkg::IDLE: begin
                if (start) n_state = timer_pkg::RUNNING;
            end
            timer_pkg::RUNNING: begin
                // Pause wins, otherwise the mode is taken up at terminal count
                if (off_signal) begin
                    n_state = timer_pkg::OFF;
                end else if (at_zero) begin
                    if (one_shot)      n_state = timer_pkg::ONE_SHOT;
                    else if (periodic) n_state = timer_pkg::PERIODIC;
                    else if (pwm_mode) n_state = timer_pkg::PWM;
                end
            end
            timer_pkg::ONE_SHOT: n_state = timer_pkg::IDLE;
            timer_pkg::PERIODIC: n_state = timer_pkg::RUNNING;
            timer_pkg::PWM:      n_state = timer_pkg::PWM_RUN;
            timer_pkg::PWM_RUN: begin
                if (at_zero) n_state = timer_pkg::PWM;
            end
            timer_pkg::OFF: begin
                if (!off_signal) n_state = timer_pkg::RUNNING;
            end
            default: n_state = timer_pkg::IDLE;
        endcase
    end

    always_comb begin
        enable        = 1'b0;
        reload_signal = 1'b0;
        timeout       = 1'b0;
        pwm_signal    = 1'b0;
        case (c_state)
            timer_pkg::IDLE:    reload_signal = 1'b1;
            timer_pkg::RUNNING: enable = !off_signal;  // Hold count on the way to OFF
            timer_pkg::ONE_SHOT: begin
                timeout       = 1'b1;
                reload_signal = 1'b1;
            end
            timer_pkg::PERIODIC: begin
                timeout       = 1'b1;
                reload_signal = 1'b1;  // Next period starts from LOAD
            end
            timer_pkg::PWM:     reload_signal = 1'b1;
            timer_pkg::PWM_RUN: begin
                enable     = 1'b1;
                pwm_signal = 1'b1;
            end
            default: ;  // OFF holds everything
        endcase
    end

endmodule

//--- hw/down_counter.sv
`timescale 1ns/1ps

module down_counter (
    input  logic                          prescaled_clk,
    input  logic                          reset_n,
    input  logic                          enable,
    input  logic                          reload_signal,
    input  logic [timer_pkg::COUNT_W-1:0] load_value,
    output logic [timer_pkg::COUNT_W-1:0] current_count
);

    logic                          at_zero;
    logic [timer_pkg::COUNT_W-1:0] count_dec;

    assign at_zero   = (current_count == '0);
    assign count_dec = current_count - 1'b1;

    // Reload has priority over counting
    always_ff @(posedge prescaled_clk or negedge reset_n) begin
        if (!reset_n) begin
            current_count <= '0;
        end else if (reload_signal) begin
            current_count <= load_value;
        end else if (enable && !at_zero) begin
            current_count <= count_dec;  // Sticks at zero, no wrap
        end
    end

endmodule

//--- hw/timer_result.sv
`timescale 1ns/1ps

module timer_result (
    input  logic                          prescaled_clk,
    input  logic                          reset_n,
    input  logic                          timeout,
    input  logic                          pwm_signal,
    input  logic [timer_pkg::COUNT_W-1:0] current_count,
    input  logic [timer_pkg::COUNT_W-1:0] duty_value,
    input  logic                          irq_en,
    input  logic                          status_clear,
    output logic                          status_flag,
    output logic [timer_pkg::EVENT_W-1:0] event_count,
    output logic                          irq,
    output logic                          pwm_out
);

    logic                          pwm_high;
    logic [timer_pkg::EVENT_W-1:0] event_base;

    assign pwm_high = pwm_signal && (current_count < duty_value);

    // A clear in the same cycle as a timeout still records that timeout
    assign event_base = status_clear ? '0 : event_count;

    always_ff @(posedge prescaled_clk or negedge reset_n) begin
        if (!reset_n) begin
            status_flag <= 1'b0;
            event_count <= '0;
        end else if (timeout) begin
            status_flag <= 1'b1;
            event_count <= event_base + 1'b1;  // Wraps after 255
        end else if (status_clear) begin
            status_flag <= 1'b0;
            event_count <= '0;
        end
    end

    always_ff @(posedge prescaled_clk or negedge reset_n) begin
        if (!reset_n) begin
            irq     <= 1'b0;
            pwm_out <= 1'b0;
        end else begin
            irq     <= status_flag && irq_en;  // Level interrupt
            pwm_out <= pwm_high;
        end
    end

endmodule

//--- hw/timer_top.sv
`timescale 1ns/1ps

module timer_top (
    input  logic                          prescaled_clk,
    input  logic                          reset_n,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [timer_pkg::ADDR_W-1:0]  wb_adr,
    input  logic [timer_pkg::COUNT_W-1:0] wb_dat_w,
    output logic [timer_pkg::COUNT_W-1:0] wb_dat_r,
    output logic                          wb_ack,
    output logic                          irq,
    output logic                          pwm_out
);

    logic                          start;
    logic                          one_shot;
    logic                          periodic;
    logic                          pwm_mode;
    logic                          off_signal;
    logic                          irq_en;
    logic                          status_clear;
    logic [timer_pkg::COUNT_W-1:0] load_value;
    logic [timer_pkg::COUNT_W-1:0] duty_value;
    logic [timer_pkg::COUNT_W-1:0] current_count;
    logic                          enable;
    logic                          reload_signal;
    logic                          pwm_signal;
    logic                          timeout;
    logic                          status_flag;
    logic [timer_pkg::EVENT_W-1:0] event_count;

    timer_regs u_regs (
        .prescaled_clk (prescaled_clk),
        .reset_n       (reset_n),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .current_count (current_count),
        .status_flag   (status_flag),
        .event_count   (event_count),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .start         (start),
        .one_shot      (one_shot),
        .periodic      (periodic),
        .pwm_mode      (pwm_mode),
        .off_signal    (off_signal),
        .irq_en        (irq_en),
        .load_value    (load_value),
        .duty_value    (duty_value),
        .status_clear  (status_clear)
    );

    count_fsm u_fsm (
        .prescaled_clk (prescaled_clk),
        .reset_n       (reset_n),
        .start         (start),
        .one_shot      (one_shot),
        .periodic      (periodic),
        .pwm_mode      (pwm_mode),
        .off_signal    (off_signal),
        .current_count (current_count),
        .enable        (enable),
        .reload_signal (reload_signal),
        .pwm_signal    (pwm_signal),
        .timeout       (timeout)
    );

    down_counter u_counter (
        .prescaled_clk (prescaled_clk),
        .reset_n       (reset_n),
        .enable        (enable),
        .reload_signal (reload_signal),
        .load_value    (load_value),
        .current_count (current_count)
    );

    timer_result u_result (
        .prescaled_clk (prescaled_clk),
        .reset_n       (reset_n),
        .timeout       (timeout),
        .pwm_signal    (pwm_signal),
        .current_count (current_count),
        .duty_value    (duty_value),
        .irq_en        (irq_en),
        .status_clear  (status_clear),
        .status_flag   (status_flag),
        .event_count   (event_count),
        .irq           (irq),
        .pwm_out       (pwm_out)
    );

endmodule

//--- tb/timer_tb_table.svh
`ifndef TIMER_TB_TABLE_SVH
`define TIMER_TB_TABLE_SVH

// Kinds of table entry
localparam int MODE_REGS     = 0;
localparam int MODE_ONE_SHOT = 1;
localparam int MODE_PERIODIC = 2;
localparam int MODE_PWM      = 3;
localparam int MODE_OFF      = 4;
localparam int MODE_CLEAR    = 5;

localparam int NUM_TESTS = 12;

typedef struct packed {
    int          mode;
    logic [31:0] load;    // Zero means load and duty come from the LFSR
    logic [31:0] duty;
    logic        irq_en;
    int          budget;  // Clock cycles allowed for the entry
} test_entry_t;

// mode, load, duty, irq_en, budget
test_entry_t tests [NUM_TESTS] = '{
    '{MODE_REGS,     32'h1234_5678, 32'h0000_00a5, 1'b0, 80},
    '{MODE_ONE_SHOT, 32'd30,        32'd0,         1'b1, 250},
    '{MODE_ONE_SHOT, 32'd12,        32'd0,         1'b0, 150},
    '{MODE_PERIODIC, 32'd8,         32'd0,         1'b0, 200},
    '{MODE_PERIODIC, 32'd25,        32'd0,         1'b0, 400},
    '{MODE_PWM,      32'd9,         32'd4,         1'b0, 200},
    '{MODE_PWM,      32'd6,         32'd20,        1'b0, 200},
    '{MODE_OFF,      32'd200,       32'd0,         1'b0, 150},
    '{MODE_CLEAR,    32'd15,        32'd0,         1'b1, 200},
    '{MODE_PWM,      32'd0,         32'd0,         1'b0, 400},
    '{MODE_PWM,      32'd0,         32'd0,         1'b0, 400},
    '{MODE_PERIODIC, 32'd0,         32'd0,         1'b0, 520}
};

`endif

//--- tb/timer_tb.sv
`timescale 1ns/1ps

module timer_tb;

    localparam int          ACK_LIMIT    = 8;
    localparam logic [31:0] LFSR_SEED    = 32'h0158_e786;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
    localparam logic [31:0] START_BIT    = 32'd1 << timer_pkg::CTRL_START;
    localparam logic [31:0] ONE_SHOT_BIT = 32'd1 << timer_pkg::CTRL_ONE_SHOT;
    localparam logic [31:0] PERIODIC_BIT = 32'd1 << timer_pkg::CTRL_PERIODIC;
    localparam logic [31:0] PWM_BIT      = 32'd1 << timer_pkg::CTRL_PWM;
    localparam logic [31:0] OFF_BIT      = 32'd1 << timer_pkg::CTRL_OFF;
    localparam logic [31:0] IRQ_BIT      = 32'd1 << timer_pkg::CTRL_IRQ_EN;

    logic                          prescaled_clk = 1'b0;
    logic                          reset_n;
    logic                          wb_cyc;
    logic                          wb_stb;
    logic                          wb_we;
    logic [timer_pkg::ADDR_W-1:0]  wb_adr;
    logic [timer_pkg::COUNT_W-1:0] wb_dat_w;
    logic [timer_pkg::COUNT_W-1:0] wb_dat_r;
    logic                          wb_ack;
    logic                          irq;
    logic                          pwm_out;
    logic [31:0]                   lfsr_state;
    int                            error_count = 0;

    `include "timer_tb_table.svh"

    timer_top dut (.*);

    always #50 prescaled_clk = ~prescaled_clk;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Error at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("Failure at time %0t: %s", $time, what);
        error_count++;
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    task automatic draw_bits(input int n, output int value);
        int i;
        value = 0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    function automatic logic [31:0] events_of(input logic [31:0] status);
        return 32'(status[timer_pkg::STAT_EVENTS_LSB +: timer_pkg::EVENT_W]);
    endfunction

    function automatic string mode_name(input int mode);
        case (mode)
            MODE_REGS:     return "registers";
            MODE_ONE_SHOT: return "one-shot";
            MODE_PERIODIC: return "periodic";
            MODE_PWM:      return "pwm";
            MODE_OFF:      return "off pause";
            MODE_CLEAR:    return "status clear";
            default:       return "unknown";
        endcase
    endfunction

    task automatic apply_reset();
        reset_n  = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (5) @(posedge prescaled_clk);
        #1;
        reset_n = 1'b1;
    endtask

    // Classic cycle with the master holding everything until ack
    task automatic bus_access(input logic we, input logic [2:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(posedge prescaled_clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_dat_w = wdata;
        do begin
            @(posedge prescaled_clk);
            #1;
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        if (!wb_ack) begin
            report_failure($sformatf("no bus ack for register %0d", addr));
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input logic [2:0] addr, input logic [31:0] data);
        logic [31:0] ignored;
        bus_access(1'b1, addr, data, ignored);
    endtask

    task automatic bus_read(input logic [2:0] addr, output logic [31:0] data);
        bus_access(1'b0, addr, '0, data);
    endtask

    task automatic wait_flag(input int max_reads, output logic [31:0] status);
        int n;
        n = 0;
        do begin
            bus_read(timer_pkg::REG_STATUS, status);
            n++;
        end while (!status[timer_pkg::STAT_TIMEOUT] && n < max_reads);
        if (!status[timer_pkg::STAT_TIMEOUT]) begin
            report_failure("timeout flag was never set");
        end
    endtask

    task automatic wait_irq(input logic level, input int cycles);
        int n;
        n = 0;
        while (irq !== level && n < cycles) begin
            @(posedge prescaled_clk);
            #1;
            n++;
        end
        if (irq !== level) report_mismatch("irq", irq, level);
    endtask

    task automatic check_registers(input logic [31:0] load, input logic [31:0] duty);
        logic [31:0] data;
        int          a;
        bus_read(timer_pkg::REG_STATUS, data);
        if (data !== 0) report_mismatch("status", data, 0);
        bus_read(timer_pkg::REG_COUNT, data);
        if (data !== 0) report_mismatch("count", data, 0);
        if (irq !== 1'b0) report_mismatch("irq", irq, 0);
        if (pwm_out !== 1'b0) report_mismatch("pwm_out", pwm_out, 0);
        bus_write(timer_pkg::REG_LOAD, load);
        bus_write(timer_pkg::REG_DUTY, duty);
        bus_write(3'd7, 32'hffff_ffff);  // Unmapped
        bus_read(timer_pkg::REG_LOAD, data);
        if (data !== load) report_mismatch("load", data, load);
        bus_read(timer_pkg::REG_DUTY, data);
        if (data !== duty) report_mismatch("duty", data, duty);
        bus_read(timer_pkg::REG_CTRL, data);
        if (data !== 0) report_mismatch("ctrl", data, 0);
        bus_read(timer_pkg::REG_COUNT, data);  // Idle keeps reloading
        if (data !== load) report_mismatch("count", data, load);
        for (a = 5; a < 8; a++) begin
            bus_read(3'(a), data);
            if (data !== 0) report_mismatch($sformatf("register %0d", a), data, 0);
        end
    endtask

    task automatic run_one_shot(input logic [31:0] load, input logic irq_en);
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] status;
        logic [31:0] mode_bits;
        mode_bits = ONE_SHOT_BIT | (irq_en ? IRQ_BIT : 0);
        bus_write(timer_pkg::REG_LOAD, load);
        bus_write(timer_pkg::REG_CTRL, START_BIT | mode_bits);
        bus_read(timer_pkg::REG_COUNT, first);
        bus_read(timer_pkg::REG_COUNT, second);
        if (first > load) report_mismatch("count", first, load);
        if (second >= first) begin
            report_failure($sformatf("count did not fall, read %0d then %0d", first, second));
        end
        wait_flag(load + 8, status);
        if (events_of(status) !== 1) report_mismatch("event_count", events_of(status), 1);
        wait_irq(irq_en, 4);
        bus_read(timer_pkg::REG_COUNT, first);
        if (first !== load) report_mismatch("count", first, load);
        repeat (3 * (load + 2)) @(posedge prescaled_clk);
        bus_read(timer_pkg::REG_STATUS, status);
        if (events_of(status) !== 1) report_mismatch("event_count", events_of(status), 1);
        if (irq !== irq_en) report_mismatch("irq", irq, irq_en);
        bus_read(timer_pkg::REG_CTRL, first);
        if (first !== mode_bits) report_mismatch("ctrl", first, mode_bits);  // Start reads zero
    endtask

    task automatic run_periodic(input logic [31:0] load);
        logic [31:0] status;
        int          window;
        int          expected;
        int          got;
        window   = 10 * (load + 2) + (load + 2) / 2;  // Mid-period stop
        expected = window / (load + 2);
        bus_write(timer_pkg::REG_LOAD, load);
        bus_write(timer_pkg::REG_CTRL, START_BIT | PERIODIC_BIT);
        repeat (window) @(posedge prescaled_clk);
        bus_write(timer_pkg::REG_CTRL, 32'd0);
        bus_read(timer_pkg::REG_STATUS, status);
        got = int'(events_of(status));
        if (got < expected - 1 || got > expected + 1) begin
            $display("Error at time %0t: event_count is %0d, expected %0d +/- 1",
                     $time, got, expected);
            error_count++;
        end
    endtask

    task automatic measure_pwm(input logic [31:0] load, input logic [31:0] duty);
        int   expected;
        int   highs;
        int   n;
        logic seen_low;
        expected = 4 * int'((duty < load + 1) ? duty : load + 1);
        bus_write(timer_pkg::REG_LOAD, load);
        bus_write(timer_pkg::REG_DUTY, duty);
        bus_write(timer_pkg::REG_CTRL, START_BIT | PWM_BIT);
        if (duty != 0) begin
            n        = 0;
            seen_low = 1'b0;
            while (!(seen_low && pwm_out) && n < 3 * (load + 2) + 8) begin
                seen_low = seen_low || !pwm_out;
                @(posedge prescaled_clk);
                #1;
                n++;
            end
            if (!(seen_low && pwm_out)) report_failure("pwm_out never rose");
        end else begin
            repeat (2 * (load + 2)) @(posedge prescaled_clk);
        end
        highs = 0;
        repeat (4 * (load + 2)) begin
            if (pwm_out) highs++;
            @(posedge prescaled_clk);
            #1;
        end
        if (highs != expected) report_mismatch("pwm_out high cycles", highs, expected);
    endtask

    task automatic pause_count(input logic [31:0] load);
        logic [31:0] paused;
        logic [31:0] later;
        bus_write(timer_pkg::REG_LOAD, load);
        bus_write(timer_pkg::REG_CTRL, START_BIT);
        repeat (10) @(posedge prescaled_clk);
        bus_write(timer_pkg::REG_CTRL, OFF_BIT);
        bus_read(timer_pkg::REG_COUNT, paused);
        if (paused >= load) report_failure("count did not move before the pause");
        repeat (20) @(posedge prescaled_clk);
        bus_read(timer_pkg::REG_COUNT, later);
        if (later !== paused) report_mismatch("count", later, paused);
        bus_write(timer_pkg::REG_CTRL, 32'd0);
        repeat (5) @(posedge prescaled_clk);
        bus_read(timer_pkg::REG_COUNT, later);
        if (later >= paused) report_failure("count did not fall after the pause ended");
    endtask

    task automatic clear_status(input logic [31:0] load);
        logic [31:0] status;
        bus_write(timer_pkg::REG_LOAD, load);
        bus_write(timer_pkg::REG_CTRL, START_BIT | ONE_SHOT_BIT | IRQ_BIT);
        wait_flag(load + 8, status);
        wait_irq(1'b1, 4);
        bus_write(timer_pkg::REG_STATUS, 32'd1 << timer_pkg::STAT_TIMEOUT);
        bus_read(timer_pkg::REG_STATUS, status);
        if (status !== 0) report_mismatch("status", status, 0);
        wait_irq(1'b0, 4);
        bus_write(timer_pkg::REG_CTRL, START_BIT | ONE_SHOT_BIT | IRQ_BIT);  // Second timeout
        wait_flag(load + 8, status);
        if (events_of(status) !== 1) report_mismatch("event_count", events_of(status), 1);
        wait_irq(1'b1, 4);
    endtask

    initial begin : main
        test_entry_t t;
        int          i;
        int          value;
        int          errors_before;
        int          failed;
        failed     = 0;
        lfsr_state = LFSR_SEED;
        for (i = 0; i < NUM_TESTS; i++) begin
            t = tests[i];
            if (t.load == 0) begin
                draw_bits(6, value);
                t.load = 32'(3 + value % 38);
                draw_bits(6, value);
                t.duty = 32'(value % 46);
            end
            errors_before = error_count;
            apply_reset();  // Also drives every bus input idle
            case (t.mode)
                MODE_REGS:     check_registers(t.load, t.duty);
                MODE_ONE_SHOT: run_one_shot(t.load, t.irq_en);
                MODE_PERIODIC: run_periodic(t.load);
                MODE_PWM:      measure_pwm(t.load, t.duty);
                MODE_OFF:      pause_count(t.load);
                MODE_CLEAR:    clear_status(t.load);
                default:       report_failure("unknown kind of entry in the test table");
            endcase
            if (error_count != errors_before) failed++;
            $display("Test %0d %s load=%0d duty=%0d: %s", i, mode_name(t.mode), t.load,
                     t.duty, (error_count == errors_before) ? "passed" : "failed");
        end
        $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 NUM_TESTS, NUM_TESTS - failed, failed, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        int i;
        limit = 200;  // Reset and bus slack
        for (i = 0; i < NUM_TESTS; i++) limit += tests[i].budget;
        repeat (limit) @(posedge prescaled_clk);
        $display("Watchdog expired: the tests did not finish within %0d clock cycles", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- all.f
+incdir+tb
hw/timer_pkg.sv
hw/timer_regs.sv
hw/count_fsm.sv
hw/down_counter.sv
hw/timer_result.sv
hw/timer_top.sv
tb/timer_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps --top-module timer_tb \
    -f all.f -o timer_sim --Mdir obj_dir > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/timer_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0
